// File: Makefile
# Verilator build and run of the AES-128 core testbench.

VERILATOR ?= verilator
TOP ?= tb_aes_encrypt
OBJ_DIR ?= obj_dir
FILELIST ?= files.f
VFLAGS ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: files.f
hw/aes_types_pkg.sv
hw/aes_ctrl_pkg.sv
hw/sbox_word.sv
hw/aes_round.sv
hw/key_expand.sv
hw/aes_block_sequencer.sv
hw/aes_encrypt_top.sv
test/aes_encrypt_properties.sv
test/tb_aes_encrypt.sv

// File: hw/aes_block_sequencer.sv
// runs one block at a time through the round unit; start is ignored while busy.
// done pulses 31 cycles after acceptance, ciphertext holds until the next start.
`timescale 1ns/100ps
`default_nettype none

module aes_block_sequencer
(
	input logic round_clk,
	input logic round_rst_n,
	input logic start,
	input logic out_valid,
	input aes_types_pkg::state_t plaintext,
	input aes_types_pkg::state_t cipher_key,
	input aes_types_pkg::state_t state_out,
	output logic busy,
	output logic done,
	output logic round_valid,
	output logic final_round,
	output logic key_load,
	output logic key_step,
	output aes_types_pkg::state_t round_state_in,
	output aes_types_pkg::state_t ciphertext
);

	import aes_types_pkg::*;
	import aes_ctrl_pkg::*;

	seq_state_t state;
	logic [3:0] round_cnt;
	state_t block_state;
	logic accept;
	logic next_round;
	logic finish;

	assign accept = start && (state == idle);
	assign busy = (state != idle);

	// a round result either launches the next round or ends the block.
	assign next_round = (state == wait_round) && out_valid && (round_cnt != num_rounds);
	assign finish = (state == wait_round) && out_valid && (round_cnt == num_rounds);

	assign round_valid = (state == launch) || next_round;
	assign final_round = round_valid && (round_cnt == num_rounds - 1);
	assign round_state_in = (state == launch) ? block_state : state_out;

	// the key expander follows the round launches.
	assign key_load = accept;
	assign key_step = round_valid;

	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
		begin
			state <= idle;
			round_cnt <= '0;
			done <= 1'b0;
			ciphertext <= '0;
		end
		else
		begin
			done <= finish;
			if (round_valid)
				round_cnt <= round_cnt + 4'd1;
			case (state)
				idle:
					if (start)
					begin
						state <= launch;
						round_cnt <= '0;
					end
				launch:
					state <= wait_round;
				default:
					if (finish)
					begin
						state <= idle;
						ciphertext <= state_out;
					end
			endcase
		end
	end

	// initial key addition.
	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
			block_state <= '0;
		else if (accept)
			block_state <= plaintext ^ cipher_key;
	end

endmodule

`default_nettype wire

// File: hw/aes_ctrl_pkg.sv
// control constants for AES-128 sequencing and key expansion.
`default_nettype none

package aes_ctrl_pkg;

	// AES-128 always runs ten rounds.
	localparam int num_rounds = 10;

	// cycles from a round launch to its registered result.
	localparam int round_lat = 3;

	typedef logic [7:0] rcon_t;

	// constant used for the first round key.
	localparam rcon_t rcon_first = 8'h01;

	typedef enum logic [1:0]
	{
		idle,
		launch,
		wait_round
	} seq_state_t;

endpackage

`default_nettype wire

// File: hw/aes_encrypt_top.sv
// AES-128 encryption core, one block in flight.
// plaintext and cipher_key are sampled with an accepted start.
`timescale 1ns/100ps
`default_nettype none

module aes_encrypt_top
(
	input logic round_clk,
	input logic round_rst_n,
	input logic start,
	input aes_types_pkg::state_t plaintext,
	input aes_types_pkg::state_t cipher_key,
	output logic busy,
	output logic done,
	output aes_types_pkg::state_t ciphertext
);

	import aes_types_pkg::*;

	logic round_valid;
	logic final_round;
	logic out_valid;
	logic key_load;
	logic key_step;
	state_t round_state_in;
	state_t state_out;
	state_t round_key;

	aes_block_sequencer u_sequencer
	(
		.round_clk(round_clk),
		.round_rst_n(round_rst_n),
		.start(start),
		.out_valid(out_valid),
		.plaintext(plaintext),
		.cipher_key(cipher_key),
		.state_out(state_out),
		.busy(busy),
		.done(done),
		.round_valid(round_valid),
		.final_round(final_round),
		.key_load(key_load),
		.key_step(key_step),
		.round_state_in(round_state_in),
		.ciphertext(ciphertext)
	);

	aes_round u_round
	(
		.round_clk(round_clk),
		.round_rst_n(round_rst_n),
		.in_valid(round_valid),
		.final_round(final_round),
		.state_in(round_state_in),
		.round_key(round_key),
		.state_out(state_out),
		.out_valid(out_valid)
	);

	// the round key is ready before stage three of each round.
	key_expand u_key_expand
	(
		.round_clk(round_clk),
		.round_rst_n(round_rst_n),
		.key_load(key_load),
		.key_step(key_step),
		.cipher_key(cipher_key),
		.round_key(round_key)
	);

endmodule

`default_nettype wire

// File: hw/aes_round.sv
// three-stage AES round: shift rows and sub bytes, mix columns, add round key.
// fixed latency of three cycles; final_round skips mix columns.
// round_key is sampled by stage three only.
`timescale 1ns/100ps
`default_nettype none

module aes_round
(
	input logic round_clk,
	input logic round_rst_n,
	input logic in_valid,
	input logic final_round,
	input aes_types_pkg::state_t state_in,
	input aes_types_pkg::state_t round_key,
	output aes_types_pkg::state_t state_out,
	output logic out_valid
);

	import aes_types_pkg::*;

	state_t sub_state;
	state_t mixed;
	state_t mix_state;
	logic valid_s1;
	logic final_s1;
	logic valid_s2;

	// output column c takes row r from input column (c + r) mod 4.
	function automatic word_t shift_col(input state_t s, input int c);
		word_t w;
		for (int r = 0; r < 4; r++)
		begin
			w[31 - 8 * r -: 8] = s[127 - 8 * (4 * ((c + r) % 4) + r) -: 8];
		end
		return w;
	endfunction

	function automatic word_t mix_col(input word_t w);
		byte_t a0;
		byte_t a1;
		byte_t a2;
		byte_t a3;
		a0 = w[31:24];
		a1 = w[23:16];
		a2 = w[15:8];
		a3 = w[7:0];
		return {
			xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
		};
	endfunction

	// stage one, row shift feeds the S-box registers directly.
	for (genvar c = 0; c < 4; c++)
	begin : g_col
		sbox_word u_sbox
		(
			.round_clk(round_clk),
			.round_rst_n(round_rst_n),
			.en(in_valid),
			.word_in(shift_col(state_in, c)),
			.word_out(sub_state[127 - 32 * c -: 32])
		);
	end

	always_comb
	begin
		for (int c = 0; c < 4; c++)
		begin
			mixed[127 - 32 * c -: 32] = mix_col(sub_state[127 - 32 * c -: 32]);
		end
	end

	// valid and final flags travel beside the data.
	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
		begin
			valid_s1 <= 1'b0;
			final_s1 <= 1'b0;
			valid_s2 <= 1'b0;
			out_valid <= 1'b0;
		end
		else
		begin
			valid_s1 <= in_valid;
			if (in_valid)
				final_s1 <= final_round;
			valid_s2 <= valid_s1;
			out_valid <= valid_s2;
		end
	end

	// stages two and three.
	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
		begin
			mix_state <= '0;
			state_out <= '0;
		end
		else
		begin
			if (valid_s1)
				mix_state <= final_s1 ? sub_state : mixed;
			if (valid_s2)
				state_out <= mix_state ^ round_key;
		end
	end

endmodule

`default_nettype wire

// File: hw/aes_types_pkg.sv
// datapath types for AES-128 and the forward S-box.
// state words are ordered with column 0 in the most significant 32 bits.
`default_nettype none

package aes_types_pkg;

	typedef logic [127:0] state_t;
	typedef logic [31:0] word_t;
	typedef logic [7:0] byte_t;

	// forward S-box, entry 0 in the leftmost byte, two table rows per literal.
	localparam byte_t [0:255] sbox_table = {
		256'h637c777bf26b6fc53001672bfed7ab76_ca82c97dfa5947f0add4a2af9ca472c0,
		256'hb7fd9326363ff7cc34a5e5f171d83115_04c723c31896059a071280e2eb27b275,
		256'h09832c1a1b6e5aa0523bd6b329e32f84_53d100ed20fcb15b6acbbe394a4c58cf,
		256'hd0efaafb434d338545f9027f503c9fa8_51a3408f929d38f5bcb6da2110fff3d2,
		256'hcd0c13ec5f974417c4a77e3d645d1973_60814fdc222a908846eeb814de5e0bdb,
		256'he0323a0a4906245cc2d3ac629195e479_e7c8376d8dd54ea96c56f4ea657aae08,
		256'hba78252e1ca6b4c6e8dd741f4bbd8b8a_703eb5664803f60e613557b986c11d9e,
		256'he1f8981169d98e949b1e87e9ce5528df_8ca1890dbfe6426841992d0fb054bb16
	};

	// multiply by x in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1.
	function automatic byte_t xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

endpackage

`default_nettype wire

// File: hw/key_expand.sv
// on-the-fly AES-128 key schedule, one round key per key_step.
// round_key changes two cycles after key_step and holds until the next step.
`timescale 1ns/100ps
`default_nettype none

module key_expand
(
	input logic round_clk,
	input logic round_rst_n,
	input logic key_load,
	input logic key_step,
	input aes_types_pkg::state_t cipher_key,
	output aes_types_pkg::state_t round_key
);

	import aes_types_pkg::*;
	import aes_ctrl_pkg::*;

	rcon_t rcon;
	logic step_d;
	word_t rot_word;
	word_t sub_word;
	word_t temp;
	word_t w0;
	word_t w1;
	word_t w2;
	word_t w3;

	// rotate the last word left by one byte.
	assign rot_word = {round_key[23:0], round_key[31:24]};

	sbox_word u_sbox
	(
		.round_clk(round_clk),
		.round_rst_n(round_rst_n),
		.en(key_step),
		.word_in(rot_word),
		.word_out(sub_word)
	);

	// xor chain over the four words of the current key.
	assign temp = sub_word ^ {rcon, 24'h000000};
	assign w0 = round_key[127:96] ^ temp;
	assign w1 = round_key[95:64] ^ w0;
	assign w2 = round_key[63:32] ^ w1;
	assign w3 = round_key[31:0] ^ w2;

	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
		begin
			rcon <= rcon_first;
			step_d <= 1'b0;
		end
		else
		begin
			step_d <= key_step;
			if (key_load)
				rcon <= rcon_first;
			else if (step_d)
				rcon <= xtime(rcon);
		end
	end

	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
			round_key <= '0;
		else if (key_load)
			round_key <= cipher_key;
		else if (step_d)
			round_key <= {w0, w1, w2, w3};
	end

endmodule

`default_nettype wire

// File: hw/sbox_word.sv
// four parallel S-box lookups with a registered output.
// word_out holds its value while en is low.
`timescale 1ns/100ps
`default_nettype none

module sbox_word
(
	input logic round_clk,
	input logic round_rst_n,
	input logic en,
	input aes_types_pkg::word_t word_in,
	output aes_types_pkg::word_t word_out
);

	import aes_types_pkg::*;

	word_t sub_next;

	// each byte goes through the table independently.
	assign sub_next = {
		sbox_table[word_in[31:24]],
		sbox_table[word_in[23:16]],
		sbox_table[word_in[15:8]],
		sbox_table[word_in[7:0]]
	};

	always_ff @(posedge round_clk)
	begin
		if (!round_rst_n)
			word_out <= '0;
		else if (en)
			word_out <= sub_next;
	end

endmodule

`default_nettype wire

// File: test/aes_cases.txt
// plaintext key expected_ciphertext, each 128-bit hex, one case per line
// FIPS-197 appendix B and C.1 first, then ECB and known-answer vectors with changing keys
3243f6a8885a308d313198a2e0370734 2b7e151628aed2a6abf7158809cf4f3c 3925841d02dc09fbdc118597196a0b32
00112233445566778899aabbccddeeff 000102030405060708090a0b0c0d0e0f 69c4e0d86a7b0430d8cdb78070b4c55a
6bc1bee22e409f96e93d7e117393172a 2b7e151628aed2a6abf7158809cf4f3c 3ad77bb40d7a3660a89ecaf32466ef97
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
ae2d8a571e03ac9c9eb76fac45af8e51 2b7e151628aed2a6abf7158809cf4f3c f5d3d58503b9699de785895a96fdbaaf
00000000000000000000000000000000 10a58869d74be5a374cf867cfb473859 6d251e6944b051e04eaa6fb4dbf78465
30c81c46a35ce411e5fbc1191a0a52ef 2b7e151628aed2a6abf7158809cf4f3c 43b1cd7f598ece23881b00e3ed030688
f34481ec3cc627bacd5dc3fb08f273e6 00000000000000000000000000000000 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 80000000000000000000000000000000 0edd33d3c621e546455bd8ba1418bec8
f69f2445df4f9b17ad2b417be66c3710 2b7e151628aed2a6abf7158809cf4f3c 7b0c785e27e8ad3f8223207104725dd4
9798c4640bad75c7c3227db910174e72 00000000000000000000000000000000 a9a1631bf4996954ebc093957b234589
80000000000000000000000000000000 00000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34

// File: test/aes_encrypt_properties.sv
// protocol checks on the core's start, busy and done, bound into aes_encrypt_top.
// assumes one block in flight and no start during reset.
`timescale 1ns/100ps
`default_nettype none

module aes_encrypt_properties
(
	input logic round_clk,
	input logic round_rst_n,
	input logic start,
	input logic busy,
	input logic done
);

	import aes_ctrl_pkg::*;

	// initial key addition plus three cycles per round.
	localparam int done_latency = num_rounds * round_lat + 1;

	done_one_cycle: assert property (
		@(posedge round_clk) disable iff (!round_rst_n)
		done |=> !done
	) else $error("done stayed high for more than one cycle");

	busy_low_at_done: assert property (
		@(posedge round_clk) disable iff (!round_rst_n)
		done |-> !busy
	) else $error("busy still high while done is high");

	// done is registered on the 31st edge and samples high one edge later.
	start_to_done: assert property (
		@(posedge round_clk) disable iff (!round_rst_n)
		(start && !busy) |=> ##done_latency done
	) else $error("done did not follow an accepted start at the fixed latency");

endmodule

bind aes_encrypt_top aes_encrypt_properties u_aes_encrypt_properties
(
	.round_clk(round_clk),
	.round_rst_n(round_rst_n),
	.start(start),
	.busy(busy),
	.done(done)
);

`default_nettype wire

// File: test/tb_aes_encrypt.sv
// testbench for the AES-128 core, cases come from test/aes_cases.txt run from the project root.
// one block at a time; done is expected 31 cycles after the edge that samples start.
`timescale 1ns/100ps
`default_nettype none

module tb_aes_encrypt;

	import aes_types_pkg::*;

	localparam int done_latency = 31;
	localparam int done_timeout = 100;
	localparam int max_gap = 6;

	logic round_clk;
	logic round_rst_n;
	logic start;
	state_t plaintext;
	state_t cipher_key;
	logic busy;
	logic done;
	state_t ciphertext;

	state_t case_pt[$];
	state_t case_key[$];
	state_t case_exp[$];

	int seed;
	int error_count;
	int test_count;
	int pass_count;
	logic timed_out;

	aes_encrypt_top u_aes_encrypt_top
	(
		.round_clk(round_clk),
		.round_rst_n(round_rst_n),
		.start(start),
		.plaintext(plaintext),
		.cipher_key(cipher_key),
		.busy(busy),
		.done(done),
		.ciphertext(ciphertext)
	);

	initial
	begin
		round_clk = 1'b0;
		forever #5 round_clk = ~round_clk;
	end

	task automatic check_state(input string name, input state_t got, input state_t exp);
		if (got !== exp)
		begin
			$display("ERROR t=%0t %s: got %h, expected %h", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("ERROR t=%0t %s: got %b, expected %b", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp)
		begin
			$display("ERROR t=%0t %s: got %0d, expected %0d", $time, name, got, exp);
			error_count++;
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		test_count++;
		if (error_count == errors_before)
		begin
			pass_count++;
			$display("%s: ok", name);
		end
		else
			$display("%s: %0d error(s)", name, error_count - errors_before);
	endtask

	// lines starting with // are column notes.
	task automatic load_cases(output logic ok);
		int fd;
		int n;
		string line;
		state_t pt;
		state_t key;
		state_t exp;
		ok = 1'b0;
		fd = $fopen("test/aes_cases.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the case file test/aes_cases.txt");
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.substr(0, 1) != "//")
			begin
				if ($sscanf(line, "%h %h %h", pt, key, exp) == 3)
				begin
					case_pt.push_back(pt);
					case_key.push_back(key);
					case_exp.push_back(exp);
				end
			end
		end
		$fclose(fd);
		ok = (case_pt.size() > 0);
		if (!ok)
			$display("no cases were found in test/aes_cases.txt");
	endtask

	// reset is released on the fourth edge and checked once more after it.
	task automatic check_reset();
		int errors_before;
		errors_before = error_count;
		for (int i = 0; i < 4; i++)
		begin
			@(posedge round_clk);
			if (i == 3)
				round_rst_n <= 1'b1;
			@(negedge round_clk);
			check_flag("busy", busy, 1'b0);
			check_flag("done", done, 1'b0);
			check_state("ciphertext", ciphertext, '0);
		end
		@(negedge round_clk);
		check_flag("busy", busy, 1'b0);
		check_flag("done", done, 1'b0);
		check_state("ciphertext", ciphertext, '0);
		report_test("reset", errors_before);
	endtask

	// intrude_at above zero pulses a second start with other data that many cycles in.
	task automatic run_block(input state_t pt, input state_t key, input state_t exp,
		input int intrude_at, input string name);
		int errors_before;
		int cycles;
		int gap;
		logic done_seen;
		errors_before = error_count;
		@(posedge round_clk);
		start <= 1'b1;
		plaintext <= pt;
		cipher_key <= key;
		@(posedge round_clk);
		start <= 1'b0;
		cycles = 0;
		done_seen = 1'b0;
		while (!done_seen && cycles < done_timeout)
		begin
			@(posedge round_clk);
			cycles++;
			if (cycles == intrude_at)
			begin
				start <= 1'b1;
				plaintext <= ~pt;
				cipher_key <= ~key;
			end
			else
				start <= 1'b0;
			@(negedge round_clk);
			if (done)
				done_seen = 1'b1;
			else
				check_flag("busy", busy, 1'b1);
		end
		if (!done_seen)
		begin
			$display("%s: done did not rise within %0d cycles of start", name, done_timeout);
			error_count++;
			timed_out = 1'b1;
			report_test(name, errors_before);
			return;
		end
		check_count("done latency", cycles, done_latency);
		check_flag("busy", busy, 1'b0);
		check_state("ciphertext", ciphertext, exp);
		// the result must hold through the idle gap.
		gap = $unsigned($random(seed)) % max_gap;
		@(negedge round_clk);
		check_flag("done", done, 1'b0);
		check_state("ciphertext", ciphertext, exp);
		for (int i = 0; i < gap; i++)
		begin
			@(negedge round_clk);
			check_state("ciphertext", ciphertext, exp);
		end
		report_test(name, errors_before);
	endtask

	initial
	begin
		logic cases_ok;
		int intrude;
		seed = 22;
		error_count = 0;
		test_count = 0;
		pass_count = 0;
		timed_out = 1'b0;
		round_rst_n = 1'b0;
		start = 1'b0;
		plaintext = '0;
		cipher_key = '0;
		load_cases(cases_ok);
		if (!cases_ok)
			error_count++;
		else
		begin
			check_reset();
			for (int i = 0; i < case_pt.size() && !timed_out; i++)
				run_block(case_pt[i], case_key[i], case_exp[i], 0, $sformatf("case %0d", i));
			if (!timed_out)
			begin
				intrude = 5 + $unsigned($random(seed)) % 20;
				run_block(case_pt[0], case_key[0], case_exp[0], intrude, "start while busy");
			end
		end
		$display("tests: %0d, passed: %0d, failed: %0d, errors: %0d",
			test_count, pass_count, test_count - pass_count, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
